// File: common/ddr_buf_config.svh
`ifndef DDR_BUF_CONFIG_SVH
`define DDR_BUF_CONFIG_SVH

// ==================================================
// host and ddr widths
// ==================================================

// host word
`define DWIDTH 16

// ddr beat
`define BWIDTH 64

// host words per beat
`define RATE 4
`define RATELOG 2

// ==================================================
// buffer geometry
// ==================================================

// beats per burst buffer
`define BURST_LEN 4
`define BUFSIZE 2

// beat addresses and lengths
`define IMGSIZE 16
`define LWIDTH 16

`endif

// File: common/ddr_buf_pkg.sv
`default_nettype none

`include "ddr_buf_config.svh"

package ddr_buf_pkg;

  // one ddr beat, raw or split into host words (lane 0 low)
  typedef union packed {
    logic [`BWIDTH-1:0]              raw;
    logic [`RATE-1:0][`DWIDTH-1:0]   word;
  } beat_t;

  typedef enum logic {
    DDR_READ  = 1'b0,
    DDR_WRITE = 1'b1
  } ddr_mode_t;

  // request toward ddr, req is a single-cycle pulse
  typedef struct packed {
    logic                 req;
    ddr_mode_t            mode;
    logic [`IMGSIZE-1:0]  base;
    logic [`LWIDTH-1:0]   len;
  } ddr_cmd_t;

  // beats fed back by ddr
  typedef struct packed {
    logic                 we;
    logic [`IMGSIZE-1:0]  waddr;
    beat_t                wdata;
    logic                 re;
    logic [`IMGSIZE-1:0]  raddr;
  } ddr_fb_t;

endpackage

`default_nettype wire

// File: prefetch/prefetch_buf.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module prefetch_buf
  ( input  wire                       clk
  , input  wire                       xrst
  , input  wire                       prefetch
  , input  wire [`IMGSIZE-1:0]        base_addr
  , input  wire [`LWIDTH-1:0]         total_len
  , input  wire [`IMGSIZE-1:0]        mem_addr
  , output logic [`DWIDTH-1:0]        mem_rdata
  , output ddr_buf_pkg::ddr_cmd_t     pref_cmd
  , input  wire                       pref_grant
  , input  wire ddr_buf_pkg::ddr_fb_t ddr_fb
  );

  logic [`IMGSIZE-1:0]  base_q;
  logic [`LWIDTH-1:0]   len_q;
  logic [`LWIDTH-1:0]   beat_cnt_q;
  logic [`LWIDTH-1:0]   beats;
  logic                 active_q;
  logic                 fill_we;
  logic [`BUFSIZE-1:0]  buf_addr;
  logic [`RATELOG-1:0]  lane_q;
  ddr_buf_pkg::beat_t   rd_beat;

  // ==================================================
  // request
  // ==================================================

  // words rounded up to beats
  assign beats = `LWIDTH'(total_len[`LWIDTH-1:`RATELOG])
               + `LWIDTH'(|total_len[`RATELOG-1:0]);

  always_comb begin
    pref_cmd.req  = prefetch;
    pref_cmd.mode = ddr_buf_pkg::DDR_READ;
    pref_cmd.base = base_addr;
    pref_cmd.len  = beats > `LWIDTH'(`BURST_LEN) ? `LWIDTH'(`BURST_LEN) : beats;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      base_q     <= '0;
      len_q      <= '0;
      beat_cnt_q <= '0;
      active_q   <= 1'b0;
    end else begin
      if (prefetch) begin
        base_q <= base_addr;
        len_q  <= pref_cmd.len;
      end
      if (pref_grant) begin
        active_q   <= 1'b1;
        beat_cnt_q <= '0;
      end else if (fill_we) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (beat_cnt_q + 1'b1 == len_q) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // ==================================================
  // burst storage and host reads
  // ==================================================

  assign fill_we  = active_q && ddr_fb.we;
  assign buf_addr = fill_we ? `BUFSIZE'(ddr_fb.waddr - base_q)
                            : mem_addr[`RATELOG +: `BUFSIZE];

  mem_sp #(.width(`BWIDTH), .depth(`BUFSIZE)) u_mem (
    .clk       (clk),
    .mem_we    (fill_we),
    .mem_addr  (buf_addr),
    .mem_wdata (ddr_fb.wdata.raw),
    .mem_rdata (rd_beat)
  );

  // lane follows the registered read
  always_ff @(posedge clk) begin
    lane_q <= mem_addr[`RATELOG-1:0];
  end

  assign mem_rdata = rd_beat.word[lane_q];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f sim.f --top-module tb_ddr_buf \
  -Mdir obj_dir -o tb_ddr_buf

out=$(./obj_dir/tb_ddr_buf)
echo "$out"

if grep -qx "STATUS: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: sim.f
+incdir+common
common/ddr_buf_pkg.sv
src/mem_sp.sv
prefetch/prefetch_buf.sv
write_path/write_pingpong.sv
src/ddr_arbiter.sv
src/ddr_buf_top.sv
testbench/ddr_buf_checker.sv
testbench/tb_ddr_buf.sv

// File: src/ddr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module ddr_arbiter
  ( input  wire                         clk
  , input  wire                         xrst
  , input  wire ddr_buf_pkg::ddr_cmd_t  pref_cmd
  , input  wire ddr_buf_pkg::ddr_cmd_t  wr_cmd
  , output logic                        pref_grant
  , output logic                        wr_grant
  , input  wire ddr_buf_pkg::ddr_fb_t   ddr_fb
  , input  wire ddr_buf_pkg::beat_t     drain_beat
  , output ddr_buf_pkg::ddr_cmd_t       ddr_cmd
  , output ddr_buf_pkg::beat_t          ddr_rdata
  );

  ddr_buf_pkg::ddr_cmd_t  pend_pref_q;
  ddr_buf_pkg::ddr_cmd_t  pend_wr_q;
  ddr_buf_pkg::ddr_cmd_t  pref_sel;
  ddr_buf_pkg::ddr_cmd_t  wr_sel;
  logic                   pref_avail;
  logic                   wr_avail;
  logic                   issue_pref;
  logic                   issue_wr;
  logic                   busy_q;
  logic [`LWIDTH-1:0]     beat_cnt_q;
  logic                   beat;
  logic                   fwd_q;

  // ==================================================
  // request selection
  // ==================================================

  // a fresh pulse goes straight through, otherwise the held one
  assign pref_avail = pref_cmd.req || pend_pref_q.req;
  assign wr_avail   = wr_cmd.req || pend_wr_q.req;
  assign pref_sel   = pref_cmd.req ? pref_cmd : pend_pref_q;
  assign wr_sel     = wr_cmd.req ? wr_cmd : pend_wr_q;

  // prefetch first
  assign issue_pref = !busy_q && pref_avail;
  assign issue_wr   = !busy_q && !pref_avail && wr_avail;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      pend_pref_q <= '0;
      pend_wr_q   <= '0;
    end else begin
      if (issue_pref) begin
        pend_pref_q.req <= 1'b0;
      end else if (pref_cmd.req) begin
        pend_pref_q <= pref_cmd;
      end
      if (issue_wr) begin
        pend_wr_q.req <= 1'b0;
      end else if (wr_cmd.req) begin
        pend_wr_q <= wr_cmd;
      end
    end
  end

  // ==================================================
  // port and beat tracking
  // ==================================================

  assign beat = busy_q && (ddr_cmd.mode == ddr_buf_pkg::DDR_READ ? ddr_fb.we : ddr_fb.re);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_cmd    <= '0;
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      pref_grant <= 1'b0;
      wr_grant   <= 1'b0;
      fwd_q      <= 1'b0;
    end else begin
      pref_grant  <= issue_pref;
      wr_grant    <= issue_wr;
      ddr_cmd.req <= 1'b0;
      if (issue_pref || issue_wr) begin
        ddr_cmd     <= issue_pref ? pref_sel : wr_sel;
        ddr_cmd.req <= 1'b1;
        busy_q      <= 1'b1;
        beat_cnt_q  <= '0;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (beat_cnt_q + 1'b1 == ddr_cmd.len) begin
          busy_q <= 1'b0;
        end
      end
      // ddr samples one cycle after re
      fwd_q <= busy_q && ddr_cmd.mode == ddr_buf_pkg::DDR_WRITE && ddr_fb.re;
    end
  end

  assign ddr_rdata = fwd_q ? drain_beat : '0;

endmodule

`default_nettype wire

// File: src/ddr_buf_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module ddr_buf_top
  ( input  wire                       clk
  , input  wire                       xrst
  // host control
  , input  wire                       prefetch
  , input  wire [`IMGSIZE-1:0]        base_addr
  , input  wire [`LWIDTH-1:0]         total_len
  // host data
  , input  wire                       mem_we
  , input  wire [`IMGSIZE-1:0]        mem_addr
  , input  wire [`DWIDTH-1:0]         mem_wdata
  , output logic [`DWIDTH-1:0]        mem_rdata
  // ddr side
  , output ddr_buf_pkg::ddr_cmd_t     ddr_cmd
  , input  wire ddr_buf_pkg::ddr_fb_t ddr_fb
  , output ddr_buf_pkg::beat_t        ddr_rdata
  );

  ddr_buf_pkg::ddr_cmd_t  pref_cmd;
  ddr_buf_pkg::ddr_cmd_t  wr_cmd;
  ddr_buf_pkg::beat_t     drain_beat;
  logic                   pref_grant;
  logic                   wr_grant;

  prefetch_buf u_prefetch (
    .clk        (clk),
    .xrst       (xrst),
    .prefetch   (prefetch),
    .base_addr  (base_addr),
    .total_len  (total_len),
    .mem_addr   (mem_addr),
    .mem_rdata  (mem_rdata),
    .pref_cmd   (pref_cmd),
    .pref_grant (pref_grant),
    .ddr_fb     (ddr_fb)
  );

  write_pingpong u_write (
    .clk        (clk),
    .xrst       (xrst),
    .base_addr  (base_addr),
    .total_len  (total_len),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata),
    .wr_cmd     (wr_cmd),
    .wr_grant   (wr_grant),
    .ddr_fb     (ddr_fb),
    .drain_beat (drain_beat)
  );

  ddr_arbiter u_arbiter (
    .clk        (clk),
    .xrst       (xrst),
    .pref_cmd   (pref_cmd),
    .wr_cmd     (wr_cmd),
    .pref_grant (pref_grant),
    .wr_grant   (wr_grant),
    .ddr_fb     (ddr_fb),
    .drain_beat (drain_beat),
    .ddr_cmd    (ddr_cmd),
    .ddr_rdata  (ddr_rdata)
  );

endmodule

`default_nettype wire

// File: src/mem_sp.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module mem_sp #(
  parameter int width = `BWIDTH,
  parameter int depth = `BUFSIZE
) ( input  wire              clk
  , input  wire              mem_we
  , input  wire [depth-1:0]  mem_addr
  , input  wire [width-1:0]  mem_wdata
  , output logic [width-1:0] mem_rdata
  );

  logic [width-1:0] mem [0:(1<<depth)-1];

  // registered read returns the old word during a write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule

`default_nettype wire

// File: testbench/ddr_buf_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module ddr_buf_checker
  ( input  wire                         clk
  , input  wire                         xrst
  , input  wire ddr_buf_pkg::ddr_cmd_t  ddr_cmd
  , input  wire [`DWIDTH-1:0]           mem_rdata
  );

  ddr_buf_pkg::ddr_cmd_t  cmd_q [$];
  string                  test_name;
  int                     test_err;
  int                     check_cnt;
  int                     err_cnt;
  int                     test_cnt;
  int                     test_fail_cnt;

  initial begin
    test_err      = 0;
    check_cnt     = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    test_name     = "none";
  end

  // collect every request that leaves the port
  always @(negedge clk) begin
    if (xrst && ddr_cmd.req) begin
      cmd_q.push_back(ddr_cmd);
    end
  end

  // ==================================================
  // compare helpers
  // ==================================================

  task automatic check_value(input string sig, input logic [63:0] exp,
                             input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      test_err++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, sig, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    check_cnt++;
    err_cnt++;
    test_err++;
    $display("error at %0t in %s: %s", $time, test_name, what);
  endtask

  task automatic check_rdata(input int idx, input logic [`DWIDTH-1:0] exp);
    check_value($sformatf("mem_rdata[word %0d]", idx), 64'(exp), 64'(mem_rdata));
  endtask

  // oldest request seen must match
  task automatic check_cmd(input logic mode, input logic [`IMGSIZE-1:0] base,
                           input logic [`LWIDTH-1:0] len);
    ddr_buf_pkg::ddr_cmd_t c;
    if (cmd_q.size() == 0) begin
      report_failure("no ddr request was seen");
    end else begin
      c = cmd_q.pop_front();
      check_value("ddr_cmd.mode", 64'(mode), 64'(c.mode));
      check_value("ddr_cmd.base", 64'(base), 64'(c.base));
      check_value("ddr_cmd.len", 64'(len), 64'(c.len));
    end
  endtask

  task automatic check_no_cmd();
    if (cmd_q.size() != 0) begin
      report_failure($sformatf("%0d unexpected ddr requests", cmd_q.size()));
      cmd_q.delete();
    end
  endtask

  // ==================================================
  // per test lines
  // ==================================================

  task automatic start_test(input string name);
    test_name = name;
    test_err  = 0;
    test_cnt++;
  endtask

  task automatic end_test();
    if (test_err == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d errors", test_name, test_err);
    end
  endtask

  task automatic report_counts();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
  endtask

endmodule

`default_nettype wire

// File: testbench/tb_ddr_buf.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module tb_ddr_buf;

  localparam logic OP_PREF  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  typedef struct packed {
    logic                 op;
    logic [`IMGSIZE-1:0]  base;
    logic [`LWIDTH-1:0]   total;
    logic [`LWIDTH-1:0]   exp_beats;
  } row_t;

  localparam int NROWS = 5;

  row_t rows [NROWS] = '{
    '{OP_PREF,  16'd100, 16'd16, 16'd4},
    '{OP_PREF,  16'd201, 16'd6,  16'd2},
    '{OP_WRITE, 16'd300, 16'd16, 16'd4},
    '{OP_WRITE, 16'd402, 16'd40, 16'd10},
    '{OP_WRITE, 16'd500, 16'd7,  16'd2}
  };

  logic                   clk;
  logic                   xrst;
  logic                   prefetch;
  logic [`IMGSIZE-1:0]    base_addr;
  logic [`LWIDTH-1:0]     total_len;
  logic                   mem_we;
  logic [`IMGSIZE-1:0]    mem_addr;
  logic [`DWIDTH-1:0]     mem_wdata;
  logic [`DWIDTH-1:0]     mem_rdata;
  ddr_buf_pkg::ddr_cmd_t  ddr_cmd;
  ddr_buf_pkg::ddr_fb_t   ddr_fb;
  ddr_buf_pkg::beat_t     ddr_rdata;

  logic [15:0]            lfsr;
  logic [`BWIDTH-1:0]     read_mem [int];
  logic [`BWIDTH-1:0]     write_mem [int];
  logic [`DWIDTH-1:0]     sent_words [$];
  int                     done_cnt;
  int                     cycles;
  int                     limit;

  ddr_buf_top dut (
    .clk       (clk),
    .xrst      (xrst),
    .prefetch  (prefetch),
    .base_addr (base_addr),
    .total_len (total_len),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .ddr_cmd   (ddr_cmd),
    .ddr_fb    (ddr_fb),
    .ddr_rdata (ddr_rdata)
  );

  ddr_buf_checker chk (
    .clk       (clk),
    .xrst      (xrst),
    .ddr_cmd   (ddr_cmd),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  // ==================================================
  // ddr model
  // ==================================================

  task automatic serve_ddr();
    logic [`IMGSIZE-1:0] b;
    logic [`LWIDTH-1:0]  n;
    logic                mode;
    logic [`BWIDTH-1:0]  beat;
    b    = ddr_cmd.base;
    n    = ddr_cmd.len;
    mode = ddr_cmd.mode;
    @(negedge clk);
    if (mode == ddr_buf_pkg::DDR_READ) begin
      for (int i = 0; i < int'(n); i++) begin
        beat             = take_bits(`BWIDTH);
        read_mem[b + i]  = beat;
        ddr_fb.we        = 1'b1;
        ddr_fb.waddr     = b + `IMGSIZE'(i);
        ddr_fb.wdata.raw = beat;
        @(negedge clk);
      end
      ddr_fb.we = 1'b0;
    end else begin
      // data for each re arrives one cycle later
      for (int i = 0; i <= int'(n); i++) begin
        if (i > 0) begin
          write_mem[b + i - 1] = ddr_rdata.raw;
        end
        if (i < int'(n)) begin
          ddr_fb.re    = 1'b1;
          ddr_fb.raddr = b + `IMGSIZE'(i);
          @(negedge clk);
        end else begin
          ddr_fb.re = 1'b0;
        end
      end
    end
    done_cnt++;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (xrst && ddr_cmd.req) begin
        serve_ddr();
      end
    end
  end

  // ==================================================
  // test procedures
  // ==================================================

  task automatic wait_done(input int target);
    while (done_cnt < target) begin
      @(negedge clk);
    end
  endtask

  task automatic run_prefetch(input row_t r);
    int                 target;
    logic [`BWIDTH-1:0] beat;
    target    = done_cnt + 1;
    base_addr = r.base;
    total_len = r.total;
    prefetch  = 1'b1;
    @(negedge clk);
    prefetch = 1'b0;
    chk.check_value("ddr_cmd.req", 64'd1, 64'(ddr_cmd.req));
    wait_done(target);
    chk.check_cmd(ddr_buf_pkg::DDR_READ, r.base, r.exp_beats);
    for (int i = 0; i < int'(r.total); i++) begin
      mem_addr = `IMGSIZE'(i);
      @(negedge clk);
      beat = read_mem[r.base + i / `RATE];
      chk.check_rdata(i, `DWIDTH'(beat >> (`DWIDTH * (i % `RATE))));
    end
    chk.check_no_cmd();
  endtask

  task automatic run_write(input row_t r);
    int                 nbursts;
    int                 target;
    int                 idx;
    int                 a;
    logic [`BWIDTH-1:0] exp;
    nbursts = (int'(r.exp_beats) + `BURST_LEN - 1) / `BURST_LEN;
    target  = done_cnt + nbursts;
    sent_words.delete();
    write_mem.delete();
    base_addr = r.base;
    total_len = r.total;
    for (int i = 0; i < int'(r.total); i++) begin
      mem_we    = 1'b1;
      mem_wdata = `DWIDTH'(take_bits(`DWIDTH));
      sent_words.push_back(mem_wdata);
      @(negedge clk);
    end
    mem_we = 1'b0;
    wait_done(target);
    for (int k = 0; k < nbursts; k++) begin
      chk.check_cmd(ddr_buf_pkg::DDR_WRITE, r.base + `IMGSIZE'(k * `BURST_LEN),
                    `LWIDTH'(int'(r.exp_beats) - k * `BURST_LEN > `BURST_LEN ?
                             `BURST_LEN : int'(r.exp_beats) - k * `BURST_LEN));
    end
    // lane 0 in the low bits and unwritten lanes zero
    for (int b = 0; b < int'(r.exp_beats); b++) begin
      exp = '0;
      for (int l = 0; l < `RATE; l++) begin
        idx = b * `RATE + l;
        if (idx < int'(r.total)) begin
          exp = exp | (`BWIDTH'(sent_words[idx]) << (`DWIDTH * l));
        end
      end
      a = int'(r.base) + b;
      if (write_mem.exists(a)) begin
        chk.check_value($sformatf("ddr_rdata[beat %0d]", b), exp, write_mem[a]);
      end else begin
        chk.report_failure($sformatf("no write beat received for address %0d", a));
      end
    end
    chk.check_no_cmd();
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    lfsr      = 16'd73;
    done_cnt  = 0;
    xrst      = 1'b0;
    prefetch  = 1'b0;
    base_addr = '0;
    total_len = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    ddr_fb    = '0;
    repeat (2) @(negedge clk);
    xrst = 1'b1;

    chk.start_test("reset_idle");
    repeat (4) begin
      @(negedge clk);
      chk.check_value("ddr_cmd.req", 64'd0, 64'(ddr_cmd.req));
    end
    chk.check_no_cmd();
    chk.end_test();

    for (int t = 0; t < NROWS; t++) begin
      chk.start_test($sformatf("%s_%0d_words", rows[t].op == OP_PREF ? "prefetch" : "write",
                               rows[t].total));
      if (rows[t].op == OP_PREF) begin
        run_prefetch(rows[t]);
      end else begin
        run_write(rows[t]);
      end
      chk.end_test();
      repeat (2) @(negedge clk);
    end

    chk.report_counts();
    if (chk.err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // run limit from the table lengths
  initial begin
    limit = 0;
    for (int i = 0; i < NROWS; i++) begin
      limit += 4 * (int'(rows[i].total) + 20);
    end
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: write_path/write_pingpong.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_buf_config.svh"

module write_pingpong
  ( input  wire                       clk
  , input  wire                       xrst
  , input  wire [`IMGSIZE-1:0]        base_addr
  , input  wire [`LWIDTH-1:0]         total_len
  , input  wire                       mem_we
  , input  wire [`DWIDTH-1:0]         mem_wdata
  , output ddr_buf_pkg::ddr_cmd_t     wr_cmd
  , input  wire                       wr_grant
  , input  wire ddr_buf_pkg::ddr_fb_t ddr_fb
  , output ddr_buf_pkg::beat_t        drain_beat
  );

  logic [`LWIDTH-1:0]   word_cnt_q;
  logic [`RATELOG-1:0]  lane_q;
  ddr_buf_pkg::beat_t   acc_q;
  ddr_buf_pkg::beat_t   acc_next;
  logic                 last_word;
  logic                 beat_done;
  logic                 buf_done;
  // fill side
  logic                 fill_buf_q;
  logic [`BUFSIZE-1:0]  fill_beat_q;
  logic [`IMGSIZE-1:0]  buf_first_q;
  logic                 beat_we_q;
  logic                 beat_buf_q;
  logic [`BUFSIZE-1:0]  beat_addr_q;
  // drain side
  logic                 req_buf_q;
  logic                 drain_buf_q;
  logic [`IMGSIZE-1:0]  drain_base_q;
  logic [`BUFSIZE-1:0]  drain_addr;
  logic [`BWIDTH-1:0]   buf_rdata [2];

  // ==================================================
  // word packing
  // ==================================================

  assign last_word = mem_we && word_cnt_q + 1'b1 == total_len;
  assign beat_done = mem_we && (lane_q == `RATELOG'(`RATE-1) || last_word);
  assign buf_done  = beat_done && (fill_beat_q == `BUFSIZE'(`BURST_LEN-1) || last_word);

  // new beat starts from zero so short beats keep upper lanes clear
  always_comb begin
    acc_next = (lane_q == '0) ? '0 : acc_q;
    acc_next.word[lane_q] = mem_wdata;
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      acc_q <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      word_cnt_q   <= '0;
      lane_q       <= '0;
      fill_buf_q   <= 1'b0;
      fill_beat_q  <= '0;
      buf_first_q  <= '0;
      beat_we_q    <= 1'b0;
      beat_buf_q   <= 1'b0;
      beat_addr_q  <= '0;
      req_buf_q    <= 1'b0;
      drain_buf_q  <= 1'b0;
      drain_base_q <= '0;
      wr_cmd       <= '0;
    end else begin
      beat_we_q  <= beat_done;
      wr_cmd.req <= buf_done;
      if (mem_we) begin
        word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
        lane_q     <= beat_done ? '0 : lane_q + 1'b1;
      end
      if (beat_done) begin
        beat_buf_q  <= fill_buf_q;
        beat_addr_q <= fill_beat_q;
        fill_beat_q <= buf_done ? '0 : fill_beat_q + 1'b1;
      end
      // full buffer or end of stream
      if (buf_done) begin
        fill_buf_q  <= last_word ? 1'b0 : ~fill_buf_q;
        buf_first_q <= last_word ? '0 : buf_first_q + `IMGSIZE'(`BURST_LEN);
        req_buf_q   <= fill_buf_q;
        wr_cmd.mode <= ddr_buf_pkg::DDR_WRITE;
        wr_cmd.base <= base_addr + buf_first_q;
        wr_cmd.len  <= `LWIDTH'(fill_beat_q) + 1'b1;
      end
      if (wr_grant) begin
        drain_buf_q  <= req_buf_q;
        drain_base_q <= wr_cmd.base;
      end
    end
  end

  // ==================================================
  // ping-pong buffers
  // ==================================================

  assign drain_addr = `BUFSIZE'(ddr_fb.raddr - drain_base_q);

  for (genvar i = 0; i < 2; i++) begin : g_buf
    logic fill_sel;

    assign fill_sel = beat_we_q && beat_buf_q == 1'(i);

    mem_sp #(.width(`BWIDTH), .depth(`BUFSIZE)) u_mem (
      .clk       (clk),
      .mem_we    (fill_sel),
      .mem_addr  (fill_sel ? beat_addr_q : drain_addr),
      .mem_wdata (acc_q.raw),
      .mem_rdata (buf_rdata[i])
    );
  end

  assign drain_beat = buf_rdata[drain_buf_q];

endmodule

`default_nettype wire
